// ==== logic/read_bypass.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per read port bypass of in-flight writes
// newest matching write wins, constant override on top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module read_bypass #(
  parameter int write_ports = 3,
  parameter int read_ports  = 2
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      read_en,
  input  regfile_pkg::read_req_t  [read_ports-1:0]  rd,
  input  regfile_pkg::write_req_t [write_ports-1:0] wr_live,
  input  regfile_pkg::write_req_t [write_ports-1:0] stage1,
  input  regfile_pkg::write_req_t [write_ports-1:0] stage2,
  input  regfile_pkg::data_t      [read_ports-1:0]  ram_data,
  output regfile_pkg::data_t      [read_ports-1:0]  read_data
);

  localparam int num_gen = 3 * write_ports;

  // all in-flight writes, oldest generation at the low end
  regfile_pkg::write_req_t [num_gen-1:0] gen;

  logic               [read_ports-1:0] hit_nxt;
  regfile_pkg::data_t [read_ports-1:0] hit_data_nxt;

  // state captured at the read edge
  logic               [read_ports-1:0] const_q;
  regfile_pkg::data_t [read_ports-1:0] const_val_q;
  logic               [read_ports-1:0] hit_q;
  regfile_pkg::data_t [read_ports-1:0] hit_data_q;

  assign gen = {wr_live, stage1, stage2};

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // match search
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // scan from oldest to newest so the last match is the newest
  // write, higher port wins within one generation
  always_comb begin
    for (int p = 0; p < read_ports; p++) begin
      hit_nxt[p]      = 1'b0;
      hit_data_nxt[p] = '0;
      for (int g = 0; g < num_gen; g++) begin
        if (gen[g].wen && (gen[g].addr == rd[p].addr)) begin
          hit_nxt[p]      = 1'b1;
          hit_data_nxt[p] = gen[g].data;
        end
      end
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read edge registers
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // reset selects a zero constant so the outputs start at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      const_q     <= '1;
      const_val_q <= '0;
      hit_q       <= '0;
    end else if (read_en) begin
      for (int p = 0; p < read_ports; p++) begin
        const_q[p]     <= rd[p].const_en;
        const_val_q[p] <= rd[p].const_val;
        hit_q[p]       <= hit_nxt[p];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read_en) begin
      hit_data_q <= hit_data_nxt;
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result mux
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // constant first, then bypass, then storage
  always_comb begin
    for (int p = 0; p < read_ports; p++) begin
      if (const_q[p]) begin
        read_data[p] = const_val_q[p];
      end else if (hit_q[p]) begin
        read_data[p] = hit_data_q[p];
      end else begin
        read_data[p] = ram_data[p];
      end
    end
  end

endmodule

// ==== logic/regfile_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// physical register file shared definitions
// widths plus the write and read port request structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package regfile_pkg;

  // register value width
  localparam int data_width = 32;

  // physical register count and its address width
  localparam int num_regs   = 64;
  localparam int addr_width = 6;

  typedef logic [data_width-1:0] data_t;
  typedef logic [addr_width-1:0] addr_t;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // port requests
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one write port, addr and data only meaningful with wen high
  typedef struct packed {
    logic  wen;
    addr_t addr;
    data_t data;
  } write_req_t;

  // one read port
  // const_en replaces the register value with const_val
  typedef struct packed {
    addr_t addr;
    logic  const_en;
    data_t const_val;
  } read_req_t;

endpackage

// ==== logic/regfile_ram.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register storage with several write ports
// reads are registered and gated by the read clock enable
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regfile_ram #(
  parameter int write_ports = 3,
  parameter int read_ports  = 2
) (
  input  logic                                      clk,
  input  logic                                      read_en,
  input  regfile_pkg::addr_t      [read_ports-1:0]  read_addr,
  input  regfile_pkg::write_req_t [write_ports-1:0] wr,
  output regfile_pkg::data_t      [read_ports-1:0]  ram_data
);

  regfile_pkg::data_t mem [regfile_pkg::num_regs];

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // ports applied in order so the highest port wins a collision
  always_ff @(posedge clk) begin
    for (int w = 0; w < write_ports; w++) begin
      if (wr[w].wen) begin
        mem[wr[w].addr] <= wr[w].data;
      end
    end
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // old contents are captured, writes of this edge are not seen
  always_ff @(posedge clk) begin
    if (read_en) begin
      for (int p = 0; p < read_ports; p++) begin
        ram_data[p] <= mem[read_addr[p]];
      end
    end
  end

endmodule

// ==== logic/regfile_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// physical register file top
// write pipeline, storage and read bypass
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regfile_top #(
  parameter int write_ports = 3,
  parameter int read_ports  = 2
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  regfile_pkg::write_req_t [write_ports-1:0] wr,
  input  regfile_pkg::read_req_t  [read_ports-1:0]  rd,
  input  logic                                      read_en,
  output regfile_pkg::data_t      [read_ports-1:0]  read_data
);

  regfile_pkg::write_req_t [write_ports-1:0] stage1;
  regfile_pkg::write_req_t [write_ports-1:0] stage2;
  regfile_pkg::addr_t      [read_ports-1:0]  read_addr;
  regfile_pkg::data_t      [read_ports-1:0]  ram_data;

  for (genvar p = 0; p < read_ports; p++) begin : g_read_addr
    assign read_addr[p] = rd[p].addr;
  end

  write_stage #(
    .write_ports (write_ports)
  ) u_write_stage (
    .clk    (clk),
    .rst    (rst),
    .wr_in  (wr),
    .stage1 (stage1),
    .stage2 (stage2)
  );

  // storage is written from the last pipeline stage
  regfile_ram #(
    .write_ports (write_ports),
    .read_ports  (read_ports)
  ) u_regfile_ram (
    .clk       (clk),
    .read_en   (read_en),
    .read_addr (read_addr),
    .wr        (stage2),
    .ram_data  (ram_data)
  );

  read_bypass #(
    .write_ports (write_ports),
    .read_ports  (read_ports)
  ) u_read_bypass (
    .clk       (clk),
    .rst       (rst),
    .read_en   (read_en),
    .rd        (rd),
    .wr_live   (wr),
    .stage1    (stage1),
    .stage2    (stage2),
    .ram_data  (ram_data),
    .read_data (read_data)
  );

endmodule

// ==== logic/write_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-stage write pipeline in front of the register storage
// both stages are exposed so reads can bypass from them
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module write_stage #(
  parameter int write_ports = 3
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  regfile_pkg::write_req_t [write_ports-1:0] wr_in,
  output regfile_pkg::write_req_t [write_ports-1:0] stage1,
  output regfile_pkg::write_req_t [write_ports-1:0] stage2
);

  always_ff @(posedge clk) begin
    // address and data only follow a valid write
    for (int i = 0; i < write_ports; i++) begin
      if (wr_in[i].wen) begin
        stage1[i].addr <= wr_in[i].addr;
        stage1[i].data <= wr_in[i].data;
      end
      if (stage1[i].wen) begin
        stage2[i].addr <= stage1[i].addr;
        stage2[i].data <= stage1[i].data;
      end
    end

    // enables
    if (rst) begin
      for (int i = 0; i < write_ports; i++) begin
        stage1[i].wen <= 1'b0;
        stage2[i].wen <= 1'b0;
      end
    end else begin
      for (int i = 0; i < write_ports; i++) begin
        stage1[i].wen <= wr_in[i].wen;
        stage2[i].wen <= stage1[i].wen;
      end
    end
  end

endmodule

// ==== tb.f ====
+incdir+test
logic/regfile_pkg.sv
logic/write_stage.sv
logic/regfile_ram.sv
logic/read_bypass.sv
logic/regfile_top.sv
test/tb_regfile.sv

// ==== test/tb_regfile_table.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed stimulus table for the register file testbench
// one row per clock, each read checked a cycle after its edge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

typedef struct packed {
  regfile_pkg::write_req_t [write_ports-1:0] wr;
  regfile_pkg::read_req_t  [read_ports-1:0]  rd;
  logic                                      read_en;
  regfile_pkg::data_t      [read_ports-1:0]  exp;
  logic                    [read_ports-1:0]  chk;
} row_t;

localparam int num_rows = 21;

row_t  table_rows [num_rows];
string row_names  [num_rows];
int    row_count;

function automatic regfile_pkg::write_req_t wr_op(input regfile_pkg::addr_t addr,
                                                  input regfile_pkg::data_t data);
  regfile_pkg::write_req_t req;
  req.wen  = 1'b1;
  req.addr = addr;
  req.data = data;
  return req;
endfunction

function automatic regfile_pkg::write_req_t idle_wr();
  return '0;
endfunction

function automatic regfile_pkg::read_req_t const_op(input regfile_pkg::addr_t addr,
                                                    input regfile_pkg::data_t val);
  regfile_pkg::read_req_t req;
  req.addr      = addr;
  req.const_en  = 1'b1;
  req.const_val = val;
  return req;
endfunction

function automatic regfile_pkg::read_req_t rd_op(input regfile_pkg::addr_t addr);
  regfile_pkg::read_req_t req;
  req           = const_op(addr, '0);
  req.const_en  = 1'b0;
  return req;
endfunction

task automatic add_row(input string name,
                       input regfile_pkg::write_req_t w0, w1, w2,
                       input regfile_pkg::read_req_t r0, r1,
                       input logic ren,
                       input regfile_pkg::data_t e0, e1);
  row_names[row_count]          = name;
  table_rows[row_count].wr      = {w2, w1, w0};
  table_rows[row_count].rd      = {r1, r0};
  table_rows[row_count].read_en = ren;
  table_rows[row_count].exp     = {e1, e0};
  table_rows[row_count].chk     = '1;
  row_count++;
endtask

task automatic fill_table();
  row_count = 0;
  // storage path, read three edges after the writes
  add_row("store_wr", wr_op(6'd5, 32'ha500_0005), wr_op(6'd6, 32'ha600_0006),
          wr_op(6'd7, 32'ha700_0007), rd_op(6'd0), rd_op(6'd0), 1'b0, 32'h0, 32'h0);
  add_row("store_gap1", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd5), rd_op(6'd6), 1'b0, 32'h0, 32'h0);
  add_row("store_gap2", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd5), rd_op(6'd6), 1'b0, 32'h0, 32'h0);
  add_row("store_rd", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd5), rd_op(6'd6), 1'b1, 32'ha500_0005, 32'ha600_0006);
  add_row("store_rd2", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd7), rd_op(6'd5), 1'b1, 32'ha700_0007, 32'ha500_0005);
  // live, stage1 and stage2 bypass, then storage
  add_row("byp_live", idle_wr(), wr_op(6'd10, 32'hb000_000a), idle_wr(),
          rd_op(6'd10), rd_op(6'd7), 1'b1, 32'hb000_000a, 32'ha700_0007);
  add_row("byp_stage1", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd6), rd_op(6'd10), 1'b1, 32'ha600_0006, 32'hb000_000a);
  add_row("byp_stage2", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd10), rd_op(6'd10), 1'b1, 32'hb000_000a, 32'hb000_000a);
  add_row("byp_ram", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd10), rd_op(6'd5), 1'b1, 32'hb000_000a, 32'ha500_0005);
  // same edge collision seen at every stage and in storage
  // newer writes on lower ports still win over it
  add_row("collide", wr_op(6'd12, 32'hc000_000c), wr_op(6'd13, 32'hc100_000d),
          wr_op(6'd12, 32'hc200_000c), rd_op(6'd12), rd_op(6'd13), 1'b1,
          32'hc200_000c, 32'hc100_000d);
  add_row("collide_newer", wr_op(6'd13, 32'hd000_000d), idle_wr(), idle_wr(),
          rd_op(6'd12), rd_op(6'd13), 1'b1, 32'hc200_000c, 32'hd000_000d);
  add_row("collide_stage", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd12), rd_op(6'd13), 1'b1, 32'hc200_000c, 32'hd000_000d);
  add_row("collide_ram", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd12), rd_op(6'd13), 1'b1, 32'hc200_000c, 32'hd000_000d);
  add_row("collide_over_ram", wr_op(6'd12, 32'hd000_000c), idle_wr(), idle_wr(),
          rd_op(6'd12), rd_op(6'd13), 1'b1, 32'hd000_000c, 32'hd000_000d);
  // constant override over an in-flight write
  add_row("const_live", wr_op(6'd20, 32'he000_0014), idle_wr(), idle_wr(),
          const_op(6'd20, 32'hcafe_0001), rd_op(6'd20), 1'b1, 32'hcafe_0001, 32'he000_0014);
  add_row("const_stage1", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd20), const_op(6'd20, 32'h0000_7777), 1'b1, 32'he000_0014, 32'h0000_7777);
  // read_en low holds the outputs
  add_row("hold_set", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd5), rd_op(6'd20), 1'b1, 32'ha500_0005, 32'he000_0014);
  add_row("hold_wr", idle_wr(), idle_wr(), wr_op(6'd5, 32'hf000_0005),
          rd_op(6'd6), rd_op(6'd7), 1'b0, 32'ha500_0005, 32'he000_0014);
  add_row("hold_const", wr_op(6'd20, 32'hf000_0014), idle_wr(), idle_wr(),
          const_op(6'd6, 32'h1234_5678), const_op(6'd7, 32'h9abc_def0), 1'b0,
          32'ha500_0005, 32'he000_0014);
  add_row("hold_release", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd5), rd_op(6'd20), 1'b1, 32'hf000_0005, 32'hf000_0014);
  add_row("hold_after", idle_wr(), idle_wr(), idle_wr(),
          rd_op(6'd12), rd_op(6'd10), 1'b0, 32'hf000_0005, 32'hf000_0014);
endtask

// ==== test/tb_regfile.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the physical register file
// directed table, then a random burst against a reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_regfile;

  localparam int write_ports   = 3;
  localparam int read_ports    = 2;
  localparam int random_cycles = 300;

  logic                                      clk;
  logic                                      rst;
  regfile_pkg::write_req_t [write_ports-1:0] wr;
  regfile_pkg::read_req_t  [read_ports-1:0]  rd;
  logic                                      read_en;
  regfile_pkg::data_t      [read_ports-1:0]  read_data;

  `include "tb_regfile_table.svh"

  localparam int watchdog_ns = (10 + num_rows + random_cycles + 20) * 8 * 2;

  regfile_pkg::data_t                  model_mem [regfile_pkg::num_regs];
  regfile_pkg::data_t [read_ports-1:0] last_exp;
  logic [31:0]                         lfsr_state;
  row_t                                prev_row;
  string                               prev_name;
  int                                  checks;
  int                                  errors;

  regfile_top uut (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr),
    .rd        (rd),
    .read_en   (read_en),
    .read_data (read_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random numbers
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // half the addresses fall in a small window so in-flight writes get hit
  function automatic regfile_pkg::addr_t random_addr();
    logic [31:0] bits;
    bits = rand_bits(1);
    if (bits[0]) begin
      bits = rand_bits(3);
    end else begin
      bits = rand_bits(6);
    end
    return bits[5:0];
  endfunction

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // row driving and checking
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_row(input string name, input row_t row);
    for (int p = 0; p < read_ports; p++) begin
      if (row.chk[p]) begin
        checks++;
        if (read_data[p] !== row.exp[p]) begin
          errors++;
          $display("ERROR %s port %0d: expected %h, actual %h",
                   name, p, row.exp[p], read_data[p]);
        end
      end
    end
  endtask

  // the previous row was sampled at this edge, so its result is out by the negedge
  task automatic run_row(input string name, input row_t row);
    @(posedge clk);
    wr      <= row.wr;
    rd      <= row.rd;
    read_en <= row.read_en;
    @(negedge clk);
    check_row(prev_name, prev_row);
    prev_name = name;
    prev_row  = row;
    if (row.read_en) begin
      last_exp = row.exp;
    end
  endtask

  task automatic build_setup_row(input int base, output row_t row);
    row = '0;
    for (int w = 0; w < write_ports; w++) begin
      if (base + w < regfile_pkg::num_regs) begin
        row.wr[w].wen  = 1'b1;
        row.wr[w].addr = regfile_pkg::addr_t'(base + w);
        row.wr[w].data = 32'h5e70_0000 + base + w;
        model_mem[base + w] = row.wr[w].data;
      end
    end
    row.exp = last_exp;
    row.chk = '1;
  endtask

  task automatic build_random_row(output row_t row);
    logic [31:0] bits;
    row = '0;
    for (int w = 0; w < write_ports; w++) begin
      bits = rand_bits(1);
      row.wr[w].wen  = bits[0];
      row.wr[w].addr = random_addr();
      row.wr[w].data = rand_bits(32);
    end
    // port order, so the higher port of one edge ends up in the model
    for (int w = 0; w < write_ports; w++) begin
      if (row.wr[w].wen) begin
        model_mem[row.wr[w].addr] = row.wr[w].data;
      end
    end
    for (int p = 0; p < read_ports; p++) begin
      row.rd[p].addr      = random_addr();
      bits                = rand_bits(3);
      row.rd[p].const_en  = (bits[2:0] == 3'd0);
      row.rd[p].const_val = rand_bits(32);
    end
    bits = rand_bits(2);
    row.read_en = (bits[1:0] != 2'd0);
    for (int p = 0; p < read_ports; p++) begin
      if (!row.read_en) begin
        row.exp[p] = last_exp[p];
      end else if (row.rd[p].const_en) begin
        row.exp[p] = row.rd[p].const_val;
      end else begin
        row.exp[p] = model_mem[row.rd[p].addr];
      end
    end
    row.chk = '1;
  endtask

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    row_t work_row;
    rst        = 1'b1;
    wr         = '0;
    rd         = '0;
    read_en    = 1'b0;
    lfsr_state = 32'hd249;
    checks     = 0;
    errors     = 0;
    last_exp   = '0;
    prev_row   = '0;
    prev_name  = "none";
    fill_table();
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // outputs leave reset at zero
    @(negedge clk);
    work_row     = '0;
    work_row.chk = '1;
    check_row("reset", work_row);

    for (int i = 0; i < num_rows; i++) begin
      run_row(row_names[i], table_rows[i]);
    end
    for (int base = 0; base < regfile_pkg::num_regs; base += write_ports) begin
      build_setup_row(base, work_row);
      run_row("setup", work_row);
    end
    for (int n = 0; n < random_cycles; n++) begin
      build_random_row(work_row);
      run_row("random", work_row);
    end

    // an idle row brings out the last random result
    work_row     = '0;
    work_row.exp = last_exp;
    work_row.chk = '1;
    run_row("flush", work_row);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
